// ==== flist.f ====
+incdir+include
rtl/chiplet_pkg.sv
rtl/flit_crc.sv
rtl/flit_counter.sv
rtl/rx_buffer.sv
rtl/req_fifo.sv
rtl/rx_fsm.sv
rtl/rx_endpoint.sv
sim/tb_rx_endpoint.sv

// ==== Makefile ====
TOP = tb_rx_endpoint

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f flist.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// ==== sim/tb_rx_endpoint.sv ====
`include "chiplet_consts.svh"

module tb_rx_endpoint;
    import chiplet_pkg::*;

    logic       clk;
    logic       n_rst;
    logic       flit_valid;
    flit_t      flit_data;
    pkt_meta_t  flit_meta;
    logic       flit_vc;
    logic       flit_taken;
    logic [1:0] credit;
    logic       crc_error;
    logic       req_pop;
    logic       req_empty;
    req_rec_t   req_rec;
    buf_addr_t  rd_addr;
    flit_t      rd_data;

    integer     seed;
    flit_t      image [2**`BUF_AW];
    req_rec_t   exp_reqs [$];
    buf_addr_t  model_addr;
    buf_addr_t  model_base;
    flit_t      pkt_words [17];
    int         pkt_len;
    pkt_meta_t  pkt_meta;
    logic       pkt_vc;
    int         taken_cnt;
    int         error_cnt;
    logic       bad;

    rx_endpoint u_dut (
        .clk        (clk),
        .n_rst      (n_rst),
        .flit_valid (flit_valid),
        .flit_data  (flit_data),
        .flit_meta  (flit_meta),
        .flit_vc    (flit_vc),
        .flit_taken (flit_taken),
        .credit     (credit),
        .crc_error  (crc_error),
        .req_pop    (req_pop),
        .req_empty  (req_empty),
        .req_rec    (req_rec),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (actual === expected) else begin
            report_fail($sformatf("Fail %s: expected %0h, actual %0h",
                                  name, expected, actual));
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Bit-serial CRC-32 with bytes and bits taken MSB first and no reflection.
    function automatic flit_t crc_next(input flit_t crc_in, input flit_t word);
        flit_t c;
        logic  fb;
        c = crc_in;
        for (int i = 31; i >= 0; i--) begin
            fb = c[31] ^ word[i];
            c = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ `CRC_POLY;
            end
        end
        return c;
    endfunction

    task automatic sample_cycle();
        @(negedge clk);
        if (flit_taken) begin
            taken_cnt++;
            check_eq("credit", 32'(2'b01 << pkt_vc), 32'(credit));
        end else begin
            check_eq("credit without take", 0, 32'(credit));
        end
        if (crc_error) begin
            error_cnt++;
        end
    endtask

    // Holds the flit until the endpoint takes it.
    task automatic offer_flit(input flit_t word, input int gap);
        int waited;
        flit_valid = 1'b0;
        for (int g = 0; g < gap; g++) begin
            sample_cycle();
            step();
        end
        flit_valid = 1'b1;
        flit_data = word;
        flit_meta = pkt_meta;
        flit_vc = pkt_vc;
        waited = 0;
        sample_cycle();
        while (!flit_taken) begin
            waited++;
            if (waited > 200) begin
                report_fail("Timeout: the endpoint did not take the offered flit");
            end
            step();
            sample_cycle();
        end
        step();
    endtask

    task automatic build_packet(input logic corrupt);
        logic [31:0] r;
        flit_t       crc;
        int          n;
        r = $random(seed);
        n = (r[3:0] == 4'd0) ? 1 : int'(r[3:0]);
        pkt_meta.id = r[8:4];
        pkt_meta.kind = r[10:9];
        pkt_vc = r[11];
        pkt_len = n + 2;
        crc = '1;
        for (int i = 0; i <= n; i++) begin
            pkt_words[i] = $random(seed);
            if (i == 0) begin
                pkt_words[0][3:0] = n[3:0];
            end
            crc = crc_next(crc, pkt_words[i]);
        end
        if (corrupt) begin
            r = $random(seed);
            crc = crc ^ ((r == 32'd0) ? 32'd1 : r);
        end
        pkt_words[n + 1] = crc;
    endtask

    task automatic check_buffer(input buf_addr_t base, input int count);
        buf_addr_t a;
        for (int i = 0; i < count; i++) begin
            a = base + buf_addr_t'(i);
            rd_addr = a;
            @(negedge clk);
            check_eq($sformatf("buffer word %0d", a), image[a], rd_data);
            step();
        end
    endtask

    task automatic send_packet(input logic corrupt, input logic no_gap);
        buf_addr_t base;
        req_rec_t  rec;
        int        gap;
        base = model_addr;
        taken_cnt = 0;
        error_cnt = 0;
        for (int i = 0; i < pkt_len; i++) begin
            gap = (no_gap && i == 0) ? 0 : int'($random(seed) & 3);
            offer_flit(pkt_words[i], gap);
            if (i < pkt_len - 1) begin
                image[model_addr] = pkt_words[i];
                model_addr = model_addr + buf_addr_t'(1);
            end
        end
        flit_valid = 1'b0;
        check_eq("taken flits", pkt_len, taken_cnt);
        check_eq("crc_error pulses", 32'(corrupt), error_cnt);
        if (corrupt) begin
            // Rollback to the start of the dropped packet.
            model_addr = model_base;
        end else begin
            rec.meta = pkt_meta;
            rec.base = model_base;
            exp_reqs.push_back(rec);
            model_base = model_addr;
            check_buffer(base, pkt_len - 1);
        end
    endtask

    task automatic check_request();
        req_rec_t exp;
        int       waited;
        exp = exp_reqs.pop_front();
        waited = 0;
        @(negedge clk);
        while (req_empty) begin
            waited++;
            if (waited > 200) begin
                report_fail("Timeout: no request appeared in the FIFO");
            end
            step();
            @(negedge clk);
        end
        check_eq("request id", exp.meta.id, req_rec.meta.id);
        check_eq("request kind", exp.meta.kind, req_rec.meta.kind);
        check_eq("request base", exp.base, req_rec.base);
        step();
        req_pop = 1'b1;
        step();
        req_pop = 1'b0;
    endtask

    initial begin
        seed = 32'hf7bd_8870;
        n_rst = 1'b0;
        flit_valid = 1'b0;
        flit_data = '0;
        flit_meta = '0;
        flit_vc = 1'b0;
        req_pop = 1'b0;
        rd_addr = '0;
        model_addr = '0;
        model_base = '0;
        repeat (3) @(posedge clk);
        #1;
        n_rst = 1'b1;
        @(negedge clk);
        check_eq("reset flit_taken", 0, flit_taken);
        check_eq("reset credit", 0, credit);
        check_eq("reset crc_error", 0, crc_error);
        check_eq("reset req_empty", 1, req_empty);
        step();

        // Random packets with each request popped as soon as it shows up.
        for (int p = 0; p < 30; p++) begin
            bad = (p == 1) || (($random(seed) & 3) == 0);
            build_packet(bad);
            send_packet(bad, 1'b0);
            if (bad) begin
                for (int k = 0; k < 4; k++) begin
                    @(negedge clk);
                    check_eq("req_empty after crc error", 1, req_empty);
                    step();
                end
            end else begin
                check_request();
            end
        end

        // Fill the FIFO; the extra request then waits inside the FSM.
        for (int p = 0; p <= `FIFO_DEPTH; p++) begin
            build_packet(1'b0);
            send_packet(1'b0, 1'b0);
        end
        build_packet(1'b0);
        flit_valid = 1'b1;
        flit_data = pkt_words[0];
        flit_meta = pkt_meta;
        flit_vc = pkt_vc;
        for (int k = 0; k < 50; k++) begin
            @(negedge clk);
            check_eq("flit taken while FIFO full", 0, flit_taken);
            step();
        end
        check_request();
        send_packet(1'b0, 1'b1);
        while (exp_reqs.size() > 0) begin
            check_request();
        end
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            check_eq("req_empty after drain", 1, req_empty);
            step();
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== rtl/rx_endpoint.sv ====
module rx_endpoint (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   flit_valid,
    input  chiplet_pkg::flit_t     flit_data,
    input  chiplet_pkg::pkt_meta_t flit_meta,
    input  logic                   flit_vc,
    output logic                   flit_taken,
    output logic [1:0]             credit,
    output logic                   crc_error,
    input  logic                   req_pop,
    output logic                   req_empty,
    output chiplet_pkg::req_rec_t  req_rec,
    input  chiplet_pkg::buf_addr_t rd_addr,
    output chiplet_pkg::flit_t     rd_data
);
    import chiplet_pkg::*;

    logic      crc_clear;
    logic      crc_update;
    logic      crc_done;
    flit_t     crc_value;
    logic      cnt_clear;
    logic      cnt_enable;
    logic      cnt_last;
    flit_cnt_t cnt_limit;
    logic      buf_wen;
    buf_addr_t buf_waddr;
    flit_t     buf_wdata;
    logic      fifo_push;
    logic      fifo_full;
    req_rec_t  fifo_rec;

    rx_fsm u_fsm (
        .clk        (clk),
        .n_rst      (n_rst),
        .flit_valid (flit_valid),
        .flit_data  (flit_data),
        .flit_meta  (flit_meta),
        .flit_vc    (flit_vc),
        .crc_done   (crc_done),
        .crc_value  (crc_value),
        .cnt_last   (cnt_last),
        .fifo_full  (fifo_full),
        .flit_taken (flit_taken),
        .credit     (credit),
        .crc_error  (crc_error),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .cnt_clear  (cnt_clear),
        .cnt_enable (cnt_enable),
        .cnt_limit  (cnt_limit),
        .buf_wen    (buf_wen),
        .buf_waddr  (buf_waddr),
        .buf_wdata  (buf_wdata),
        .fifo_push  (fifo_push),
        .fifo_rec   (fifo_rec)
    );

    flit_crc u_crc (
        .clk    (clk),
        .n_rst  (n_rst),
        .clear  (crc_clear),
        .update (crc_update),
        .word   (flit_data),
        .crc    (crc_value),
        .done   (crc_done)
    );

    flit_counter u_counter (
        .clk    (clk),
        .n_rst  (n_rst),
        .clear  (cnt_clear),
        .enable (cnt_enable),
        .limit  (cnt_limit),
        .last   (cnt_last)
    );

    rx_buffer u_buffer (
        .clk   (clk),
        .wen   (buf_wen),
        .waddr (buf_waddr),
        .wdata (buf_wdata),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

    req_fifo u_fifo (
        .clk   (clk),
        .n_rst (n_rst),
        .push  (fifo_push),
        .pop   (req_pop),
        .din   (fifo_rec),
        .dout  (req_rec),
        .full  (fifo_full),
        .empty (req_empty)
    );

endmodule

// ==== rtl/rx_fsm.sv ====
module rx_fsm (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   flit_valid,
    input  chiplet_pkg::flit_t     flit_data,
    input  chiplet_pkg::pkt_meta_t flit_meta,
    input  logic                   flit_vc,
    input  logic                   crc_done,
    input  chiplet_pkg::flit_t     crc_value,
    input  logic                   cnt_last,
    input  logic                   fifo_full,
    output logic                   flit_taken,
    output logic [1:0]             credit,
    output logic                   crc_error,
    output logic                   crc_clear,
    output logic                   crc_update,
    output logic                   cnt_clear,
    output logic                   cnt_enable,
    output chiplet_pkg::flit_cnt_t cnt_limit,
    output logic                   buf_wen,
    output chiplet_pkg::buf_addr_t buf_waddr,
    output chiplet_pkg::flit_t     buf_wdata,
    output logic                   fifo_push,
    output chiplet_pkg::req_rec_t  fifo_rec
);
    import chiplet_pkg::*;

    rx_state_e state;
    rx_state_e next_state;
    buf_addr_t wr_addr;
    buf_addr_t next_wr_addr;
    buf_addr_t base_addr;
    buf_addr_t next_base_addr;
    flit_cnt_t next_limit;
    pkt_meta_t meta_q;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= idle;
            wr_addr <= '0;
            base_addr <= '0;
            cnt_limit <= '0;
        end else begin
            state <= next_state;
            wr_addr <= next_wr_addr;
            base_addr <= next_base_addr;
            cnt_limit <= next_limit;
        end
    end

    // Id and request kind come with the header flit.
    always_ff @(posedge clk) begin
        if (state == header) begin
            meta_q <= flit_meta;
        end
    end

    always_comb begin
        next_state = state;
        next_wr_addr = wr_addr;
        next_base_addr = base_addr;
        next_limit = cnt_limit;
        flit_taken = 1'b0;
        crc_error = 1'b0;
        crc_clear = 1'b0;
        crc_update = 1'b0;
        cnt_clear = 1'b0;
        cnt_enable = 1'b0;
        buf_wen = 1'b0;
        fifo_push = 1'b0;

        case (state)
            idle: begin
                crc_clear = 1'b1;
                if (flit_valid) begin
                    next_state = header;
                end
            end
            header: begin
                // Header plus N body flits are hashed.
                next_limit = {1'b0, flit_data[3:0]} + 5'd1;
                next_state = crc_wait;
            end
            crc_wait: begin
                crc_update = 1'b1;
                if (crc_done) begin
                    flit_taken = 1'b1;
                    buf_wen = 1'b1;
                    cnt_enable = 1'b1;
                    next_wr_addr = wr_addr + buf_addr_t'(1);
                    next_state = cnt_last ? crc_check : body;
                end
            end
            body: begin
                if (flit_valid) begin
                    next_state = crc_wait;
                end
            end
            crc_check: begin
                if (flit_valid) begin
                    flit_taken = 1'b1;
                    if (flit_data == crc_value) begin
                        next_state = req_push;
                    end else begin
                        // Drop the packet so its words get overwritten later.
                        crc_error = 1'b1;
                        cnt_clear = 1'b1;
                        next_wr_addr = base_addr;
                        next_state = idle;
                    end
                end
            end
            req_push: begin
                if (!fifo_full) begin
                    fifo_push = 1'b1;
                    cnt_clear = 1'b1;
                    next_base_addr = wr_addr;
                    next_state = idle;
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    assign credit = flit_taken ? (2'b01 << flit_vc) : 2'b00;
    assign buf_waddr = wr_addr;
    assign buf_wdata = flit_data;
    assign fifo_rec = '{meta: meta_q, base: base_addr};

    // The switch must still be offering the flit we consume.
    assert property (@(posedge clk) disable iff (!n_rst) flit_taken |-> flit_valid);

    // A flit on offer stays put until it is taken.
    assert property (@(posedge clk) disable iff (!n_rst)
        flit_valid && !flit_taken |=> flit_valid && $stable(flit_data));

endmodule

// ==== rtl/req_fifo.sv ====
`include "chiplet_consts.svh"

module req_fifo (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  push,
    input  logic                  pop,
    input  chiplet_pkg::req_rec_t din,
    output chiplet_pkg::req_rec_t dout,
    output logic                  full,
    output logic                  empty
);
    import chiplet_pkg::*;

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    req_rec_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    assign full = (count == (PTR_W+1)'(DEPTH));
    assign empty = (count == '0);
    assign do_push = push && !full;
    assign do_pop = pop && !empty;
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The receive FSM holds its record while we are full.
    assert property (@(posedge clk) disable iff (!n_rst) full |-> !push);

endmodule

// ==== rtl/rx_buffer.sv ====
`include "chiplet_consts.svh"

module rx_buffer (
    input  logic                   clk,
    input  logic                   wen,
    input  chiplet_pkg::buf_addr_t waddr,
    input  chiplet_pkg::flit_t     wdata,
    input  chiplet_pkg::buf_addr_t raddr,
    output chiplet_pkg::flit_t     rdata
);
    import chiplet_pkg::*;

    flit_t mem [2**`BUF_AW];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // Inspection read without a clock.
    assign rdata = mem[raddr];

endmodule

// ==== rtl/flit_counter.sv ====
module flit_counter (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   clear,
    input  logic                   enable,
    input  chiplet_pkg::flit_cnt_t limit,
    output logic                   last
);
    import chiplet_pkg::*;

    flit_cnt_t count;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (enable) begin
            count <= count + flit_cnt_t'(1);
        end
    end

    // the next increment lands on the limit
    assign last = ((count + flit_cnt_t'(1)) == limit);

endmodule

// ==== rtl/flit_crc.sv ====
`include "chiplet_consts.svh"

module flit_crc (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               clear,
    input  logic               update,
    input  chiplet_pkg::flit_t word,
    output chiplet_pkg::flit_t crc,
    output logic               done
);
    import chiplet_pkg::*;

    logic [1:0] byte_idx;
    logic [7:0] cur_byte;

    function automatic flit_t fold_byte(flit_t c_in, logic [7:0] b);
        flit_t c;
        c = c_in ^ {b, {(`FLIT_W-8){1'b0}}};
        for (int i = 0; i < 8; i++) begin
            c = c[`FLIT_W-1] ? ((c << 1) ^ `CRC_POLY) : (c << 1);
        end
        return c;
    endfunction

    // Most significant byte first.
    assign cur_byte = word[{~byte_idx, 3'b000} +: 8];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc <= '1;
            byte_idx <= '0;
        end else if (clear) begin
            crc <= '1;
            byte_idx <= '0;
        end else if (update) begin
            crc <= fold_byte(crc, cur_byte);
            byte_idx <= byte_idx + 2'd1;
        end
    end

    assign done = update && (byte_idx == 2'd3);

    assert property (@(posedge clk) disable iff (!n_rst) !(clear && update));

endmodule

// ==== rtl/chiplet_pkg.sv ====
`include "chiplet_consts.svh"

package chiplet_pkg;

    typedef logic [`FLIT_W-1:0] flit_t;

    typedef logic [`BUF_AW-1:0] buf_addr_t;

    // Holds up to 16 hashed flits for a header plus 15 body flits.
    typedef logic [4:0] flit_cnt_t;

    typedef struct packed {
        logic [4:0] id;
        logic [1:0] kind;
    } pkt_meta_t;

    // Record handed to the request consumer.
    typedef struct packed {
        pkt_meta_t meta;
        buf_addr_t base;
    } req_rec_t;

    typedef enum logic [2:0] {
        idle, header, crc_wait, body, crc_check, req_push
    } rx_state_e;

endpackage

// ==== include/chiplet_consts.svh ====
`ifndef CHIPLET_CONSTS_SVH
`define CHIPLET_CONSTS_SVH

// Flit word width in bits.
`define FLIT_W 32

// Receive buffer word address width for 128 words.
`define BUF_AW 7

// Request FIFO entries.
`define FIFO_DEPTH 4

// CRC-32 generator polynomial shifted MSB first.
`define CRC_POLY 32'h04C1_1DB7

`endif
